//--- logic/rename_pkg.sv
package rename_pkg;

  localparam int NUM_ARCH = 32;
  localparam int NUM_PR   = 64;

  typedef logic [$clog2(NUM_ARCH)-1:0] arch_idx_t;
  typedef logic [$clog2(NUM_PR)-1:0]   pr_idx_t;

  // r31 means no destination, never renamed
  localparam arch_idx_t ZERO_REG = arch_idx_t'(31);

  // Instruction as it enters the core
  typedef struct packed {
    arch_idx_t   dest;
    logic [31:0] pc;
  } dispatch_t;

  // Rename stage -> ROB -> retire unit
  typedef struct packed {
    arch_idx_t   dest;
    pr_idx_t     new_pr;
    logic        has_dest;
    logic [31:0] pc;
  } rob_entry_t;

  typedef struct packed {
    arch_idx_t   wr_idx;
    pr_idx_t     new_pr;
    pr_idx_t     freed_pr;  // Old committed mapping of wr_idx
    logic        wr_en;
    logic [31:0] pc;        // Lets commits be matched to instructions
  } commit_t;

endpackage

//--- logic/free_list.sv
module free_list #(
  parameter int NUM_REGS = rename_pkg::NUM_PR
) (
  input  logic                clock,
  input  logic                rst_n,
  input  logic                push,
  input  rename_pkg::pr_idx_t push_pr,
  input  logic                pop,
  output rename_pkg::pr_idx_t head_pr,
  output logic                not_empty
);

  import rename_pkg::*;

  // Only the registers above the architectural range ever sit here
  localparam int DEPTH = NUM_REGS - NUM_ARCH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  pr_idx_t          fifo [DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_pr   = fifo[head];
  assign not_empty = (count != '0);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        fifo[i] <= pr_idx_t'(NUM_ARCH + i);
      end
      head  <= '0;
      tail  <= '0;  // Full at reset, tail sits on head
      count <= FULL;
    end else begin
      if (push) begin
        fifo[tail] <= push_pr;
        tail       <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Rename stage must see not_empty before popping
  assert property (@(posedge clock) disable iff (!rst_n) pop |-> not_empty)
    else $error("free list popped while empty");

  // More frees than non-architectural registers means a double free at retire
  assert property (@(posedge clock) disable iff (!rst_n) push |-> count != FULL)
    else $error("free list pushed while full");

endmodule

//--- logic/rename_stage.sv
module rename_stage #(
  parameter int ROB_DEPTH = 16
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   dispatch_valid,
  input  rename_pkg::dispatch_t  dispatch,
  output logic                   dispatch_ready,
  input  rename_pkg::pr_idx_t    free_pr,
  input  logic                   free_not_empty,
  output logic                   free_pop,
  output logic                   alloc_valid,
  output rename_pkg::rob_entry_t alloc_entry,
  input  logic                   rob_credit
);

  import rename_pkg::*;

  localparam int CRED_W = $clog2(ROB_DEPTH + 1);
  localparam logic [CRED_W-1:0] MAX_CRED = CRED_W'(ROB_DEPTH);

  pr_idx_t           map_table [NUM_ARCH];  // Speculative arch -> phys map
  logic [CRED_W-1:0] credits;
  logic              has_dest;

  function automatic logic is_mapped(input pr_idx_t pr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NUM_ARCH; i++) begin
      if (map_table[i] == pr) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  assign has_dest = (dispatch.dest != ZERO_REG);

  // A free register is needed only when something gets written
  assign dispatch_ready = (credits != '0) && (!has_dest || free_not_empty);
  assign alloc_valid    = dispatch_valid && dispatch_ready;
  assign free_pop       = alloc_valid && has_dest;

  always_comb begin
    alloc_entry.dest     = dispatch.dest;
    alloc_entry.new_pr   = has_dest ? free_pr : '0;
    alloc_entry.has_dest = has_dest;
    alloc_entry.pc       = dispatch.pc;
  end

  // Credits toward the ROB
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      credits <= MAX_CRED;
    end else begin
      case ({alloc_valid, rob_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ARCH; i++) begin
        map_table[i] <= pr_idx_t'(i);
      end
    end else if (free_pop) begin
      map_table[dispatch.dest] <= free_pr;
    end
  end

  // A register handed out by the free list is never still live in the map
  assert property (@(posedge clock) disable iff (!rst_n) free_pop |-> !is_mapped(free_pr))
    else $error("free list returned a register that is still mapped");

  assert property (@(posedge clock) disable iff (!rst_n) rob_credit |-> credits != MAX_CRED)
    else $error("ROB returned a credit it was never given");

endmodule

//--- logic/reorder_buffer.sv
module reorder_buffer #(
  parameter int ROB_DEPTH    = 16,
  parameter int COMMIT_DEPTH = 2
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         alloc_valid,
  input  rename_pkg::rob_entry_t       alloc_entry,
  output logic [$clog2(ROB_DEPTH)-1:0] alloc_idx,
  input  logic                         complete_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_idx,
  output logic                         release_valid,
  output rename_pkg::rob_entry_t       release_entry,
  input  logic                         retire_credit,
  output logic                         rob_credit
);

  import rename_pkg::*;

  localparam int IDX_W  = $clog2(ROB_DEPTH);
  localparam int CRED_W = $clog2(COMMIT_DEPTH + 1);

  rob_entry_t           entries [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] occupied;
  logic [ROB_DEPTH-1:0] done;
  logic [IDX_W-1:0]     head;
  logic [IDX_W-1:0]     tail;
  logic [CRED_W-1:0]    credits;  // Free slots in the commit queue

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (idx == IDX_W'(ROB_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign alloc_idx     = tail;
  assign release_entry = entries[head];

  // Oldest entry leaves as soon as it is done and retire has room
  assign release_valid = occupied[head] && done[head] && (credits != '0);
  assign rob_credit    = release_valid;

  always_ff @(posedge clock) begin
    if (alloc_valid) begin
      entries[tail] <= alloc_entry;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      occupied <= '0;
      done     <= '0;
      head     <= '0;
      tail     <= '0;
    end else begin
      if (alloc_valid) begin
        occupied[tail] <= 1'b1;
        done[tail]     <= 1'b0;
        tail           <= next_idx(tail);
      end
      if (complete_valid) begin
        done[complete_rob_idx] <= 1'b1;
      end
      if (release_valid) begin
        occupied[head] <= 1'b0;
        head           <= next_idx(head);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      credits <= CRED_W'(COMMIT_DEPTH);
    end else begin
      case ({release_valid, retire_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Rename credits must keep the tail off live entries
  assert property (@(posedge clock) disable iff (!rst_n) alloc_valid |-> !occupied[tail])
    else $error("ROB allocation into an occupied slot");

  assert property (@(posedge clock) disable iff (!rst_n)
                   complete_valid |-> occupied[complete_rob_idx] && !done[complete_rob_idx])
    else $error("completion of an empty or already done ROB slot");

endmodule

//--- logic/retire_unit.sv
module retire_unit #(
  parameter int COMMIT_DEPTH = 2
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   release_valid,
  input  rename_pkg::rob_entry_t release_entry,
  output logic                   free_push,
  output rename_pkg::pr_idx_t    free_pr,
  output logic                   retire_credit,
  output logic                   commit_valid,
  output rename_pkg::commit_t    commit,
  input  logic                   commit_ready
);

  import rename_pkg::*;

  localparam int PTR_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1;
  localparam int CNT_W = $clog2(COMMIT_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(COMMIT_DEPTH);

  pr_idx_t          arch_map [NUM_ARCH];  // Committed state
  commit_t          queue [COMMIT_DEPTH];
  commit_t          rec;
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(COMMIT_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Old mapping goes back to the free list at the release edge
  assign free_pr   = arch_map[release_entry.dest];
  assign free_push = release_valid && release_entry.has_dest;

  always_comb begin
    rec.wr_idx   = release_entry.dest;
    rec.new_pr   = release_entry.new_pr;
    rec.freed_pr = release_entry.has_dest ? free_pr : '0;
    rec.wr_en    = release_entry.has_dest;
    rec.pc       = release_entry.pc;
  end

  assign commit_valid  = (count != '0);
  assign commit        = queue[head];
  assign pop           = commit_valid && commit_ready;
  assign retire_credit = pop;  // One slot back to the ROB

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ARCH; i++) begin
        arch_map[i] <= pr_idx_t'(i);
      end
    end else if (free_push) begin
      arch_map[release_entry.dest] <= release_entry.new_pr;
    end
  end

  always_ff @(posedge clock) begin
    if (release_valid) begin
      queue[tail] <= rec;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (release_valid) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({release_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ROB credit count has to track queue space exactly
  assert property (@(posedge clock) disable iff (!rst_n) release_valid |-> count != FULL)
    else $error("release arrived with the commit queue full");

endmodule

//--- logic/rename_core.sv
module rename_core #(
  parameter int ROB_DEPTH    = 16,
  parameter int COMMIT_DEPTH = 2
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         dispatch_valid,
  input  rename_pkg::dispatch_t        dispatch,
  output logic                         dispatch_ready,
  output logic [$clog2(ROB_DEPTH)-1:0] dispatch_rob_idx,
  input  logic                         complete_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_idx,
  output logic                         commit_valid,
  output rename_pkg::commit_t          commit,
  input  logic                         commit_ready
);

  import rename_pkg::*;

  pr_idx_t    free_head_pr;
  logic       free_not_empty;
  logic       free_pop;
  logic       free_push;
  pr_idx_t    freed_pr;
  logic       alloc_valid;
  rob_entry_t alloc_entry;
  logic       rob_credit;     // Rename <- ROB
  logic       release_valid;
  rob_entry_t release_entry;
  logic       retire_credit;  // ROB <- retire

  rename_stage #(
    .ROB_DEPTH (ROB_DEPTH)
  ) rename_stage_0 (
    .clock          (clock),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .free_pr        (free_head_pr),
    .free_not_empty (free_not_empty),
    .free_pop       (free_pop),
    .alloc_valid    (alloc_valid),
    .alloc_entry    (alloc_entry),
    .rob_credit     (rob_credit)
  );

  free_list #(
    .NUM_REGS (NUM_PR)
  ) free_list_0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .push      (free_push),
    .push_pr   (freed_pr),
    .pop       (free_pop),
    .head_pr   (free_head_pr),
    .not_empty (free_not_empty)
  );

  reorder_buffer #(
    .ROB_DEPTH    (ROB_DEPTH),
    .COMMIT_DEPTH (COMMIT_DEPTH)
  ) rob_0 (
    .clock            (clock),
    .rst_n            (rst_n),
    .alloc_valid      (alloc_valid),
    .alloc_entry      (alloc_entry),
    .alloc_idx        (dispatch_rob_idx),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .release_valid    (release_valid),
    .release_entry    (release_entry),
    .retire_credit    (retire_credit),
    .rob_credit       (rob_credit)
  );

  retire_unit #(
    .COMMIT_DEPTH (COMMIT_DEPTH)
  ) retire_unit_0 (
    .clock         (clock),
    .rst_n         (rst_n),
    .release_valid (release_valid),
    .release_entry (release_entry),
    .free_push     (free_push),
    .free_pr       (freed_pr),
    .retire_credit (retire_credit),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .commit_ready  (commit_ready)
  );

endmodule

//--- dv/tb_rename_core.sv
module tb_rename_core;

  import rename_pkg::*;

  localparam int ROB_DEPTH    = 16;
  localparam int COMMIT_DEPTH = 2;
  localparam int IDX_W        = $clog2(ROB_DEPTH);
  localparam int RESET_CYCLES = 8;
  localparam int NUM_INSTR    = 400;
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_INSTR * 40;

  logic             clock;
  logic             rst_n;
  logic             dispatch_valid;
  dispatch_t        dispatch;
  logic             dispatch_ready;
  logic [IDX_W-1:0] dispatch_rob_idx;
  logic             complete_valid;
  logic [IDX_W-1:0] complete_rob_idx;
  logic             commit_valid;
  commit_t          commit;
  logic             commit_ready;

  logic [31:0] lfsr;
  int          cycles;
  int          dispatched;
  int          committed;
  bit          pending;     // Instruction on the port, not yet taken
  bit          ready_seen;
  bit          valid_seen;

  int          outstanding [$];  // ROB slots not yet completed
  pr_idx_t     model_free [$];
  pr_idx_t     model_map [NUM_ARCH];
  commit_t     expected [int];   // Keyed by pc

  rename_core #(
    .ROB_DEPTH    (ROB_DEPTH),
    .COMMIT_DEPTH (COMMIT_DEPTH)
  ) UUT (
    .clock            (clock),
    .rst_n            (rst_n),
    .dispatch_valid   (dispatch_valid),
    .dispatch         (dispatch),
    .dispatch_ready   (dispatch_ready),
    .dispatch_rob_idx (dispatch_rob_idx),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .commit_valid     (commit_valid),
    .commit           (commit),
    .commit_ready     (commit_ready)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d instructions committed",
                               cycles, committed, NUM_INSTR));
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_commit(input commit_t got, input commit_t exp);
    commit_t cmp;
    cmp = got;
    if (!exp.wr_en) begin  // Physical fields are don't care without a destination
      cmp.new_pr   = '0;
      cmp.freed_pr = '0;
    end
    if (cmp !== exp) begin
      report_failure($sformatf("mismatch commit: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_rob_idx(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch dispatch_rob_idx: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    end
  endtask

  // Model side of an accepted dispatch
  task automatic take_dispatch();
    commit_t exp;
    check_rob_idx(dispatch_rob_idx, IDX_W'(dispatched % ROB_DEPTH));
    exp        = '0;
    exp.wr_idx = dispatch.dest;
    exp.wr_en  = (dispatch.dest != ZERO_REG);
    exp.pc     = dispatch.pc;
    if (exp.wr_en && model_free.size() == 0) begin
      report_failure("the model free list ran dry while the core still accepted a dispatch");
    end else begin
      if (exp.wr_en) begin
        exp.new_pr = model_free.pop_front();
      end
      expected[int'(dispatch.pc)] = exp;
      outstanding.push_back(dispatched % ROB_DEPTH);
      dispatched++;
    end
  endtask

  // Commits must come in pc order
  task automatic take_commit(input commit_t got);
    commit_t exp;
    if (!expected.exists(committed)) begin
      report_failure($sformatf("commit for pc %h arrived with no instruction outstanding",
                               got.pc));
    end else begin
      exp = expected[committed];
      if (exp.wr_en) begin
        exp.freed_pr = model_map[exp.wr_idx];
      end
      check_commit(got, exp);
      if (exp.wr_en) begin
        model_map[exp.wr_idx] = exp.new_pr;
        model_free.push_back(exp.freed_pr);
      end
      expected.delete(committed);
      committed++;
    end
  endtask

  // Modes: 0 never, 1 random, 2 always
  task automatic run_cycle(input int dispatch_mode, input int complete_mode,
                           input int ready_mode);
    int unsigned r;
    int          k;
    @(negedge clock);
    complete_valid = 1'b0;
    rand_bits(1, r);
    if (outstanding.size() > 0 && (complete_mode == 2 || (complete_mode == 1 && r == 1))) begin
      rand_bits(8, r);
      k                = int'(r % outstanding.size());
      complete_valid   = 1'b1;
      complete_rob_idx = IDX_W'(outstanding[k]);
      outstanding.delete(k);
    end
    rand_bits(2, r);
    case (ready_mode)
      0:       commit_ready = 1'b0;
      1:       commit_ready = (r != 0);
      default: commit_ready = 1'b1;
    endcase
    if (!pending) begin
      rand_bits(2, r);
      if (dispatch_mode == 2 || (dispatch_mode == 1 && r != 0 && dispatched < NUM_INSTR)) begin
        rand_bits(3, r);
        if (r == 0) begin
          dispatch.dest = ZERO_REG;
        end else begin
          rand_bits(5, r);
          dispatch.dest = arch_idx_t'(r % 31);
        end
        dispatch.pc    = 32'(dispatched);
        dispatch_valid = 1'b1;
        pending        = 1'b1;
      end else begin
        dispatch_valid = 1'b0;
      end
    end
    #1;
    ready_seen = dispatch_ready;
    valid_seen = commit_valid;
    if (dispatch_valid && dispatch_ready) begin
      take_dispatch();
      pending = 1'b0;
    end
    if (commit_valid && commit_ready) begin
      take_commit(commit);
    end
  endtask

  initial begin
    bit was_full;
    clock            = 1'b0;
    rst_n            = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch         = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    commit_ready     = 1'b0;
    lfsr             = 32'h380f_9dde;
    cycles           = 0;
    dispatched       = 0;
    committed        = 0;
    pending          = 1'b0;
    for (int i = 0; i < NUM_ARCH; i++) begin
      model_map[i] = pr_idx_t'(i);
    end
    for (int i = NUM_ARCH; i < NUM_PR; i++) begin
      model_free.push_back(pr_idx_t'(i));
    end
    repeat (RESET_CYCLES) @(negedge clock);
    rst_n = 1'b1;

    run_cycle(0, 0, 0);
    check_flag("dispatch_ready", ready_seen, 1'b1);
    check_flag("commit_valid", valid_seen, 1'b0);

    // No completions, so the ROB fills and dispatch stalls
    for (int i = 0; i < ROB_DEPTH + 6; i++) begin
      was_full = (dispatched == ROB_DEPTH);
      run_cycle(2, 0, 0);
      if (was_full) begin
        check_flag("dispatch_ready", ready_seen, 1'b0);
      end
    end
    check_count("accepted dispatches", dispatched, ROB_DEPTH);

    while (outstanding.size() > 0 || pending) begin
      run_cycle(0, 2, 0);
    end
    for (int i = 0; i < 4; i++) begin
      run_cycle(0, 0, 0);
      check_flag("commit_valid", valid_seen, 1'b1);  // Held under back-pressure
    end

    while (dispatched < NUM_INSTR) begin
      run_cycle(1, 1, 1);
    end
    while (committed < dispatched || outstanding.size() > 0) begin
      run_cycle(0, 2, 2);
    end
    repeat (4) run_cycle(0, 0, 2);

    if (committed != NUM_INSTR || expected.size() != 0) begin
      report_failure($sformatf("run ended with %0d of %0d instructions committed",
                               committed, NUM_INSTR));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- rename_core.f
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_stage.sv
logic/reorder_buffer.sv
logic/retire_unit.sv
logic/rename_core.sv
dv/tb_rename_core.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rename_core.f --top-module tb_rename_core -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
